// ==== hdl/cache_geom_pkg.sv ====
package cache_geom_pkg;

   // word address, byte offset already stripped by the front end
   localparam int word_addr_w    = 14;
   localparam int offset_w       = 2;   // word within a line
   localparam int words_per_line = 2**offset_w;
   localparam int index_w        = 4;   // 16 sets
   localparam int tag_w          = 8;
   localparam int n_ways         = 4;
   localparam int line_addr_w    = tag_w + index_w;

   typedef logic [index_w-1:0]     index_t;
   typedef logic [tag_w-1:0]       tag_t;
   typedef logic [offset_w-1:0]    offset_t;
   typedef logic [line_addr_w-1:0] line_addr_t;

   // same 14 bits, two readings:
   // lookup side splits tag/index/offset, refill side wants the line number
   typedef union packed
   {
      struct packed
      {
         tag_t    tag;
         index_t  index;
         offset_t offset;
      } fields;
      struct packed
      {
         line_addr_t line;   // tag and index together
         offset_t    offset;
      } line;
   } word_addr_t;

endpackage

// ==== hdl/cache_bus_pkg.sv ====
package cache_bus_pkg;

   localparam int data_w = 32;

   typedef logic [data_w-1:0]   data_t;
   typedef logic [data_w/8-1:0] strb_t;   // one enable per byte lane

   // one bit per way, one-hot or all zero
   typedef logic [cache_geom_pkg::n_ways-1:0] way_mask_t;

   // pending write-through word, packed as {addr, data, strb}
   localparam int wbuf_entry_w = cache_geom_pkg::word_addr_w + data_w + data_w/8;

   typedef logic [wbuf_entry_w-1:0] wbuf_entry_t;

endpackage

// ==== hdl/write_buffer.sv ====
module write_buffer
#(
   parameter int depth_w = 3
)
(
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      push,
   input  cache_bus_pkg::wbuf_entry_t entry_in,
   input  logic                      pop,
   output cache_bus_pkg::wbuf_entry_t entry_out,
   output logic                      full,
   output logic                      empty
);
   import cache_bus_pkg::*;

   localparam int depth = 2**depth_w;

   wbuf_entry_t        mem [depth];
   logic [depth_w-1:0] wr_ptr;
   logic [depth_w-1:0] rd_ptr;
   logic [depth_w:0]   count;     // one extra bit to tell full from empty
   logic               pop_en;

   assign pop_en    = pop & ~empty;   // pop with nothing there is ignored
   assign full      = (count == (depth_w+1)'(depth));
   assign empty     = (count == '0);
   assign entry_out = mem[rd_ptr];    // head shows the cycle after the push

   always_ff @(posedge clk)
      if (push)
         mem[wr_ptr] <= entry_in;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
         if (pop_en)
            rd_ptr <= rd_ptr + 1'b1;
         count <= count + (push ? 1'b1 : 1'b0) - (pop_en ? 1'b1 : 1'b0);
      end
   end

   // controller holds ready low while full, so a push here means lost data
   a_no_overflow: assert property (@(posedge clk) disable iff (reset)
      !(push && full));

endmodule

// ==== hdl/plru_policy.sv ====
module plru_policy
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    invalidate,
   input  cache_geom_pkg::index_t   lookup_index,
   input  logic                    plru_update,
   input  cache_bus_pkg::way_mask_t plru_way,
   output cache_bus_pkg::way_mask_t victim
);
   import cache_geom_pkg::*;
   import cache_bus_pkg::*;

   localparam int n_sets = 2**index_w;

   way_mask_t plru_bits [n_sets];   // one "recently used" bit per way
   way_mask_t bits_q;
   way_mask_t merged;

   assign merged = plru_bits[lookup_index] | plru_way;

   always_ff @(posedge clk)
   begin
      if (reset || invalidate)
      begin
         for (int s = 0; s < n_sets; s++)
            plru_bits[s] <= '0;
         bits_q <= '0;
      end
      else
      begin
         if (plru_update)
            plru_bits[lookup_index] <= (&merged) ? '0 : merged;   // all used, start over
         bits_q <= plru_bits[lookup_index];   // sync read like the other arrays
      end
   end

   // lowest-numbered way with its bit clear, descending loop so lowest wins
   always_comb
   begin
      victim = '0;
      for (int w = n_ways-1; w >= 0; w--)
         if (!bits_q[w])
            victim = way_mask_t'(1) << w;
   end

endmodule

// ==== hdl/cache_ways.sv ====
module cache_ways
(
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      invalidate,
   input  cache_geom_pkg::index_t     lookup_index,
   input  cache_geom_pkg::word_addr_t req_addr,
   input  cache_bus_pkg::data_t       req_wdata,
   input  cache_bus_pkg::strb_t       req_wstrb,
   input  logic                      hit_write,
   input  logic                      fill_we,
   input  cache_bus_pkg::way_mask_t   fill_way,
   input  cache_geom_pkg::offset_t    fill_offset,
   input  cache_bus_pkg::data_t       fill_data,
   input  logic                      tag_we,
   output cache_bus_pkg::way_mask_t   way_hit,
   output cache_bus_pkg::data_t       hit_word
);
   import cache_geom_pkg::*;
   import cache_bus_pkg::*;

   localparam int n_sets   = 2**index_w;
   localparam int n_bytes  = $bits(strb_t);
   localparam int n_words  = 2**(index_w+offset_w);   // words per way

   logic [index_w+offset_w-1:0] waddr;
   logic [index_w+offset_w-1:0] raddr;
   data_t                       wword;
   data_t                       masked_word [n_ways];

   // refill beats and write hits never overlap, fill takes the mux when active
   assign waddr = {lookup_index, fill_we ? fill_offset : req_addr.fields.offset};
   assign raddr = {lookup_index, req_addr.fields.offset};
   assign wword = fill_we ? fill_data : req_wdata;

   for (genvar w = 0; w < n_ways; w++)
   begin : g_way
      logic [7:0]        data_mem [n_bytes][n_words];   // one array per byte lane
      tag_t              tag_mem [n_sets];
      logic [n_sets-1:0] valid_bits;
      tag_t              tag_q;
      logic              valid_q;
      data_t             word_q;
      strb_t             lane_we;

      // whole word on refill, strobed bytes on a write hit
      assign lane_we = {n_bytes{fill_we & fill_way[w]}} |
                       ({n_bytes{hit_write & way_hit[w]}} & req_wstrb);

      always_ff @(posedge clk)
      begin
         for (int b = 0; b < n_bytes; b++)
         begin
            if (lane_we[b])
               data_mem[b][waddr] <= wword[8*b +: 8];
            word_q[8*b +: 8] <= data_mem[b][raddr];   // sync read
         end
         if (tag_we && fill_way[w])
            tag_mem[lookup_index] <= req_addr.fields.tag;
         tag_q <= tag_mem[lookup_index];
      end

      // valid bits are control state, cleared by reset and invalidate
      always_ff @(posedge clk)
      begin
         if (reset || invalidate)
         begin
            valid_bits <= '0;
            valid_q    <= 1'b0;   // drop a hit already in flight
         end
         else
         begin
            if (tag_we && fill_way[w])
               valid_bits[lookup_index] <= 1'b1;
            valid_q <= valid_bits[lookup_index];
         end
      end

      assign way_hit[w]     = valid_q & (tag_q == req_addr.fields.tag);
      assign masked_word[w] = way_hit[w] ? word_q : '0;
   end

   // at most one way hits, so OR works as the select
   always_comb
   begin
      hit_word = '0;
      for (int w = 0; w < n_ways; w++)
         hit_word = hit_word | masked_word[w];
   end

   // a line is only allocated after a miss in all ways
   a_single_hit: assert property (@(posedge clk) disable iff (reset)
      $onehot0(way_hit));

endmodule

// ==== hdl/cache_control.sv ====
module cache_control
(
   input  logic                      clk,
   input  logic                      reset,
   // front end
   input  logic                      valid,
   input  cache_geom_pkg::word_addr_t addr,
   input  cache_bus_pkg::data_t       wdata,
   input  cache_bus_pkg::strb_t       wstrb,
   output cache_bus_pkg::data_t       rdata,
   output logic                      ready,
   // back-end read channel
   output logic                      replace_valid,
   output cache_geom_pkg::line_addr_t replace_addr,
   input  logic                      replace_ready,
   input  logic                      read_valid,
   input  cache_geom_pkg::offset_t    read_addr,
   input  cache_bus_pkg::data_t       read_rdata,
   // from ways, plru and buffer
   input  cache_bus_pkg::way_mask_t   way_hit,
   input  cache_bus_pkg::data_t       hit_word,
   input  cache_bus_pkg::way_mask_t   victim,
   input  logic                      wbuf_full,
   input  logic                      wbuf_empty,
   // to ways, plru and buffer
   output cache_geom_pkg::index_t     lookup_index,
   output cache_geom_pkg::word_addr_t req_addr,
   output cache_bus_pkg::data_t       req_wdata,
   output cache_bus_pkg::strb_t       req_wstrb,
   output logic                      hit_write,
   output logic                      fill_we,
   output cache_bus_pkg::way_mask_t   fill_way,
   output cache_geom_pkg::offset_t    fill_offset,
   output cache_bus_pkg::data_t       fill_data,
   output logic                      tag_we,
   output logic                      plru_update,
   output cache_bus_pkg::way_mask_t   plru_way,
   output logic                      wbuf_push,
   // status
   output logic                      read_hit,
   output logic                      read_miss,
   output logic                      write_hit,
   output logic                      write_miss
);
   import cache_geom_pkg::*;
   import cache_bus_pkg::*;

   localparam logic [2:0] st_idle    = 3'd0;
   localparam logic [2:0] st_lookup  = 3'd1;   // memories read the held index
   localparam logic [2:0] st_compare = 3'd2;   // tags out and hit decided
   localparam logic [2:0] st_drain   = 3'd3;   // let earlier writes leave first
   localparam logic [2:0] st_request = 3'd4;   // replace_valid up
   localparam logic [2:0] st_refill  = 3'd5;   // collecting beats
   localparam logic [2:0] st_tag     = 3'd6;   // tag + valid written

   logic [2:0] state;
   word_addr_t addr_q;
   data_t      wdata_q;
   strb_t      wstrb_q;
   way_mask_t  victim_q;
   offset_t    beat_cnt;
   logic       missed;      // this request already went through a refill
   logic       is_write;
   logic       hit;
   logic       miss_start;
   logic       last_beat;

   assign is_write   = |wstrb_q;   // any strobe set means write
   assign hit        = |way_hit;
   assign ready      = (state == st_compare) & (is_write ? ~wbuf_full : hit);
   assign miss_start = (state == st_compare) & ~is_write & ~hit;
   assign last_beat  = read_valid & (beat_cnt == offset_t'(words_per_line-1));

   assign rdata = hit_word;   // valid in the ready cycle of a read

   // status pulses ride on ready
   assign read_hit   = ready & ~is_write & ~missed;
   assign read_miss  = ready & ~is_write & missed;
   assign write_hit  = ready & is_write & hit;
   assign write_miss = ready & is_write & ~hit;   // no allocate on write miss

   assign lookup_index = addr_q.fields.index;
   assign req_addr     = addr_q;
   assign req_wdata    = wdata_q;
   assign req_wstrb    = wstrb_q;

   assign hit_write = write_hit;              // merge bytes into the hit way
   assign wbuf_push = ready & is_write;       // every write goes through
   // covers plain hits and the final lookup after a refill
   assign plru_update = ready & hit;
   assign plru_way    = way_hit;

   assign replace_valid = (state == st_request);
   assign replace_addr  = addr_q.line.line;
   assign fill_we       = (state == st_refill) & read_valid;
   assign fill_way      = victim_q;
   assign fill_offset   = read_addr;   // beats may arrive out of order
   assign fill_data     = read_rdata;
   assign tag_we        = (state == st_tag);

   // request payload and frozen victim
   always_ff @(posedge clk)
   begin
      if (state == st_idle && valid)
      begin
         addr_q  <= addr;
         wdata_q <= wdata;
         wstrb_q <= wstrb;
      end
      if (miss_start)
         victim_q <= victim;   // frozen for the whole refill
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= st_idle;
         missed   <= 1'b0;
         beat_cnt <= '0;
      end
      else
      begin
         case (state)
            st_idle:
               if (valid)
               begin
                  missed <= 1'b0;
                  state  <= st_lookup;
               end
            st_lookup:
               state <= st_compare;
            st_compare:
               if (ready)
                  state <= st_idle;
               else if (miss_start)
               begin
                  missed <= 1'b1;
                  state  <= st_drain;
               end   // write with buffer full just waits here
            st_drain:
               if (wbuf_empty)
                  state <= st_request;
            st_request:
               if (replace_ready)
               begin
                  beat_cnt <= '0;
                  state    <= st_refill;
               end
            st_refill:
               if (read_valid)
               begin
                  beat_cnt <= beat_cnt + 1'b1;
                  if (last_beat)
                     state <= st_tag;
               end
            st_tag:
               state <= st_lookup;   // re-read so the new line hits
            default:
               state <= st_idle;
         endcase
      end
   end

   // request and its line address hold while the back end stalls the accept
   a_replace_hold: assert property (@(posedge clk) disable iff (reset)
      replace_valid && !replace_ready |=> replace_valid && $stable(replace_addr));

endmodule

// ==== hdl/cache_top.sv ====
module cache_top
#(
   parameter int wbuf_depth_w = 3
)
(
   input  logic                      clk,
   input  logic                      reset,
   // front end
   input  logic                      valid,
   input  cache_geom_pkg::word_addr_t addr,
   input  cache_bus_pkg::data_t       wdata,
   input  cache_bus_pkg::strb_t       wstrb,
   output cache_bus_pkg::data_t       rdata,
   output logic                      ready,
   // back-end write channel
   output logic                      write_valid,
   output cache_geom_pkg::word_addr_t write_addr,
   output cache_bus_pkg::data_t       write_wdata,
   output cache_bus_pkg::strb_t       write_wstrb,
   input  logic                      write_ready,
   // back-end read channel
   output logic                      replace_valid,
   output cache_geom_pkg::line_addr_t replace_addr,
   input  logic                      replace_ready,
   input  logic                      read_valid,
   input  cache_geom_pkg::offset_t    read_addr,
   input  cache_bus_pkg::data_t       read_rdata,
   // cache control
   input  logic                      invalidate,
   output logic                      wtbuf_full,
   output logic                      wtbuf_empty,
   output logic                      read_hit,
   output logic                      read_miss,
   output logic                      write_hit,
   output logic                      write_miss
);
   import cache_geom_pkg::*;
   import cache_bus_pkg::*;

   index_t      lookup_index;
   word_addr_t  req_addr;
   data_t       req_wdata, hit_word, fill_data;
   strb_t       req_wstrb;
   way_mask_t   way_hit, victim, fill_way, plru_way;
   offset_t     fill_offset;
   logic        hit_write, fill_we, tag_we, plru_update, wbuf_push;
   logic        wbuf_full, wbuf_empty;
   wbuf_entry_t wbuf_head;

   assign write_valid = ~wbuf_empty;
   assign {write_addr, write_wdata, write_wstrb} = wbuf_head;   // oldest pending write
   assign wtbuf_full  = wbuf_full;
   assign wtbuf_empty = wbuf_empty;

   cache_control u_control (.*);   // port names match the nets above

   cache_ways u_ways (.*);

   plru_policy u_plru (.*);

   write_buffer #(.depth_w(wbuf_depth_w)) u_wbuf
   (
      .clk       (clk),
      .reset     (reset),
      .push      (wbuf_push),
      .entry_in  ({req_addr, req_wdata, req_wstrb}),
      .pop       (write_ready),   // buffer ignores it while empty
      .entry_out (wbuf_head),
      .full      (wbuf_full),
      .empty     (wbuf_empty)
   );

endmodule

// ==== sim/backend_model.sv ====
module backend_model
(
   input  logic                      clk,
   input  logic                      reset,
   // write channel
   input  logic                      write_valid,
   input  cache_geom_pkg::word_addr_t write_addr,
   input  cache_bus_pkg::data_t       write_wdata,
   input  cache_bus_pkg::strb_t       write_wstrb,
   output logic                      write_ready,
   // read channel
   input  logic                      replace_valid,
   input  cache_geom_pkg::line_addr_t replace_addr,
   output logic                      replace_ready,
   output logic                      read_valid,
   output cache_geom_pkg::offset_t    read_addr,
   output cache_bus_pkg::data_t       read_rdata
);
   import cache_geom_pkg::*;
   import cache_bus_pkg::*;

   data_t      mem [2**word_addr_w];   // whole word address space
   integer     seed;
   logic [31:0] r;
   logic       busy;      // a refill was accepted, beats still owed
   int         nsent;     // beats sent for the current line
   offset_t    key;       // xor key that scrambles the beat order
   line_addr_t line_q;
   data_t      merged;

   // one process owns both edges, handshakes taken at posedge
   initial
   begin
      seed = 40;
      for (int a = 0; a < 2**word_addr_w; a++)
         mem[a] = {2'b01, 14'(a), 2'b10, ~14'(a)};   // pattern over the full address
      busy          = 1'b0;
      nsent         = 0;
      key           = '0;
      line_q        = '0;
      r             = '0;
      write_ready   = 1'b0;
      replace_ready = 1'b0;
      read_valid    = 1'b0;
      read_addr     = '0;
      read_rdata    = '0;
      forever
      begin
         @(posedge clk);
         if (reset)
         begin
            busy  = 1'b0;
            nsent = 0;
         end
         else
         begin
            if (write_valid && write_ready)
            begin
               merged = mem[write_addr];
               for (int b = 0; b < $bits(strb_t); b++)
                  if (write_wstrb[b])
                     merged[8*b +: 8] = write_wdata[8*b +: 8];
               mem[write_addr] = merged;
            end
            if (replace_valid && replace_ready)
            begin
               busy   = 1'b1;
               line_q = replace_addr;
               key    = r[6:5];   // new beat order per line
               nsent  = 0;
            end
            else if (read_valid)
            begin
               nsent = nsent + 1;
               if (nsent == words_per_line)
                  busy = 1'b0;   // last beat gone
            end
         end
         @(negedge clk);
         r = $random(seed);
         write_ready   = !reset && (r[1:0] != 2'b00);   // stall about one cycle in four
         replace_ready = !reset && !busy && r[2];
         if (!reset && busy && r[4:3] != 2'b00)
         begin
            read_valid = 1'b1;
            read_addr  = offset_t'(nsent) ^ key;
            read_rdata = mem[{line_q, read_addr}];
         end
         else
            read_valid = 1'b0;   // gap between beats
      end
   end

endmodule

// ==== sim/cache_tb.sv ====
module cache_tb;
   import cache_geom_pkg::*;
   import cache_bus_pkg::*;

   localparam int n_random     = 400;   // requests in the random test
   localparam int n_tags       = 6;     // more tags than ways so sets evict
   localparam int n_sets       = 2**index_w;
   localparam int n_words      = 2**word_addr_w;
   localparam int max_wait     = 300;   // worst case for one request incl. drain and refill
   localparam int run_limit    = (2*n_random + n_tags*4 + 4) * max_wait;
   localparam int wbuf_depth_w = 3;
   localparam int wbuf_depth   = 2**wbuf_depth_w;   // entries in the write buffer

   logic       clk;
   logic       reset;
   logic       valid;
   word_addr_t addr;
   data_t      wdata;
   strb_t      wstrb;
   data_t      rdata;
   logic       ready;
   logic       write_valid;
   word_addr_t write_addr;
   data_t      write_wdata;
   strb_t      write_wstrb;
   logic       write_ready;
   logic       replace_valid;
   line_addr_t replace_addr;
   logic       replace_ready;
   logic       read_valid;
   offset_t    read_addr;
   data_t      read_rdata;
   logic       invalidate;
   logic       wtbuf_full;
   logic       wtbuf_empty;
   logic       read_hit;
   logic       read_miss;
   logic       write_hit;
   logic       write_miss;

   integer     seed;
   int         errors;
   int         checks;
   // model memory after all completed writes and the shadow cache state
   data_t      model_mem [n_words];
   tag_t       shadow_tag [n_sets][n_ways];
   logic       shadow_valid [n_sets][n_ways];
   way_mask_t  shadow_plru [n_sets];
   word_addr_t exp_wr_addr [$];   // writes in the order the write channel owes them
   data_t      exp_wr_data [$];
   strb_t      exp_wr_strb [$];
   tag_t       tag_pool [n_tags];
   // result of the last request
   int         last_latency;
   logic [3:0] last_flags;   // read_hit, read_miss, write_hit, write_miss
   data_t      last_rdata;

   cache_top #(.wbuf_depth_w(wbuf_depth_w)) dut (.*);

   backend_model backend (.*);

   initial
   begin
      clk = 1'b0;
      forever
         #5 clk = ~clk;
   end

   // watchdog sized from request count times worst request time
   initial
   begin
      #(run_limit * 10);
      $display("timeout: run did not finish within %0d cycles", run_limit);
      $display("Test failed");
      $finish;
   end

   task automatic check_word(input data_t got, input data_t exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_flags(input logic [3:0] got, input logic [3:0] exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Mismatch at %0t: %s got rh/rm/wh/wm %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_addr(input word_addr_t got, input word_addr_t exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_strb(input strb_t got, input strb_t exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_level(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_cycles(input int got, input int exp, input string what);
      checks++;
      if (got != exp)
      begin
         errors++;
         $display("Mismatch at %0t: %s got %0d cycles expected %0d", $time, what, got, exp);
      end
   endtask

   function automatic data_t fill_word(input int a);
      return {2'b01, 14'(a), 2'b10, ~14'(a)};   // same power-up pattern as the back end
   endfunction

   function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                         input strb_t s);
      data_t result;
      result = old_word;
      for (int b = 0; b < $bits(strb_t); b++)
         if (s[b])
            result[8*b +: 8] = new_word[8*b +: 8];
      return result;
   endfunction

   function automatic int find_way(input word_addr_t a);
      int hit_way;
      hit_way = -1;   // miss
      for (int w = 0; w < n_ways; w++)
         if (shadow_valid[a.fields.index][w] && shadow_tag[a.fields.index][w] == a.fields.tag)
            hit_way = w;
      return hit_way;
   endfunction

   // bit-PLRU marks the way used and wraps to zero once every way is marked
   function automatic void plru_touch(input index_t s, input int w);
      way_mask_t used;
      used = shadow_plru[s] | way_mask_t'(1 << w);
      shadow_plru[s] = (&used) ? '0 : used;
   endfunction

   function automatic int pick_victim(input index_t s);
      for (int w = 0; w < n_ways; w++)
         if (!shadow_plru[s][w])
            return w;   // lowest clear bit
      return 0;
   endfunction

   // starts at a falling edge and returns at the falling edge after the ready cycle
   task automatic do_request(input word_addr_t a, input data_t d, input strb_t s);
      int cycles;
      valid  = 1'b1;
      addr   = a;
      wdata  = d;
      wstrb  = s;
      cycles = 0;
      do
      begin
         @(negedge clk);
         cycles++;
      end
      while (!ready && cycles < max_wait);
      if (!ready)
      begin
         errors++;
         $display("request to %h got no ready within %0d cycles", a, max_wait);
      end
      last_latency = cycles;
      last_flags   = {read_hit, read_miss, write_hit, write_miss};
      last_rdata   = rdata;
      @(negedge clk);   // hold through the ready cycle
      valid = 1'b0;
      wstrb = '0;
   endtask

   task automatic run_read(input word_addr_t a);
      int w;
      logic [3:0] exp_flags;
      w = find_way(a);
      do_request(a, '0, '0);
      if (w >= 0)
      begin
         exp_flags = 4'b1000;
         plru_touch(a.fields.index, w);
         check_cycles(last_latency, 2, "read hit latency");
      end
      else
      begin
         exp_flags = 4'b0100;
         w = pick_victim(a.fields.index);   // refill lands in the victim way
         shadow_tag[a.fields.index][w]   = a.fields.tag;
         shadow_valid[a.fields.index][w] = 1'b1;
         plru_touch(a.fields.index, w);
      end
      check_flags(last_flags, exp_flags, "read status");
      check_word(last_rdata, model_mem[a], "read data");
      // pending writes in the queue match the buffer level
      check_level(wtbuf_full, exp_wr_addr.size() == wbuf_depth, "write buffer full");
      check_level(wtbuf_empty, exp_wr_addr.size() == 0, "write buffer empty");
   endtask

   task automatic run_write(input word_addr_t a, input data_t d, input strb_t s);
      int w;
      w = find_way(a);
      do_request(a, d, s);
      model_mem[a] = merge_bytes(model_mem[a], d, s);
      exp_wr_addr.push_back(a);
      exp_wr_data.push_back(d);
      exp_wr_strb.push_back(s);
      if (w >= 0)
      begin
         plru_touch(a.fields.index, w);
         check_flags(last_flags, 4'b0010, "write status");
      end
      else
         check_flags(last_flags, 4'b0001, "write status");   // no allocate
      check_level(wtbuf_full, exp_wr_addr.size() == wbuf_depth, "write buffer full");
      check_level(wtbuf_empty, exp_wr_addr.size() == 0, "write buffer empty");
   endtask

   task automatic pulse_invalidate();
      invalidate = 1'b1;
      @(negedge clk);
      invalidate = 1'b0;
      for (int s = 0; s < n_sets; s++)
      begin
         shadow_plru[s] = '0;
         for (int w = 0; w < n_ways; w++)
            shadow_valid[s][w] = 1'b0;
      end
   endtask

   // write channel must replay the completed writes in order
   always @(posedge clk)
      if (!reset && write_valid && write_ready)
      begin
         if (exp_wr_addr.size() == 0)
         begin
            errors++;
            $display("write channel sent a write that was never requested, time %0t", $time);
         end
         else
         begin
            check_addr(write_addr, exp_wr_addr.pop_front(), "write channel address");
            check_word(write_wdata, exp_wr_data.pop_front(), "write channel data");
            check_strb(write_wstrb, exp_wr_strb.pop_front(), "write channel strobe");
         end
      end

   initial
   begin
      word_addr_t  a;
      logic [31:0] r;
      int          e0;
      int          cycles;
      seed       = 40;
      errors     = 0;
      checks     = 0;
      reset      = 1'b1;
      valid      = 1'b0;
      addr       = '0;
      wdata      = '0;
      wstrb      = '0;
      invalidate = 1'b0;
      tag_pool   = '{8'h03, 8'h5a, 8'h81, 8'hc4, 8'h27, 8'hfe};
      for (int i = 0; i < n_words; i++)
         model_mem[i] = fill_word(i);
      for (int s = 0; s < n_sets; s++)
      begin
         shadow_plru[s] = '0;
         for (int w = 0; w < n_ways; w++)
         begin
            shadow_valid[s][w] = 1'b0;
            shadow_tag[s][w]   = '0;
         end
      end
      repeat (3) @(negedge clk);
      reset = 1'b0;

      // mixed reads and writes over four sets and six tags
      e0 = errors;
      for (int i = 0; i < n_random; i++)
      begin
         r = $random(seed);
         a.fields.tag    = tag_pool[int'(r[10:8]) % n_tags];
         a.fields.index  = index_t'(r[13:12]);
         a.fields.offset = r[15:14];
         if (r[2:0] < 3'd3)
            run_write(a, $random(seed), (r[19:16] == 4'd0) ? 4'hf : r[19:16]);
         else
         begin
            run_read(a);
            if (last_flags == 4'b0100)
               run_read(a);   // repeat right after the refill expects a 2-cycle hit
         end
      end
      $display("test random_traffic: %0d requests, %0d errors", n_random, errors - e0);

      e0 = errors;
      pulse_invalidate();
      for (int t = 0; t < n_tags; t++)
         for (int s = 0; s < 4; s++)
         begin
            a.fields.tag    = tag_pool[t];
            a.fields.index  = index_t'(s);
            a.fields.offset = offset_t'(t);
            run_read(a);
            check_flags(last_flags, 4'b0100, "first read after invalidate");
         end
      $display("test invalidate: %0d first reads, %0d errors", n_tags*4, errors - e0);

      // once the buffer empties the back-end memory must equal the model
      e0 = errors;
      cycles = 0;
      while (!wtbuf_empty && cycles < max_wait)
      begin
         @(negedge clk);
         cycles++;
      end
      if (!wtbuf_empty)
      begin
         errors++;
         $display("write buffer did not drain within %0d cycles", max_wait);
      end
      if (exp_wr_addr.size() != 0)
      begin
         errors++;
         $display("%0d writes never left on the write channel", exp_wr_addr.size());
      end
      for (int i = 0; i < n_words; i++)
         check_word(backend.mem[i], model_mem[i], $sformatf("back-end word %h", i));
      $display("test drain: %0d words compared, %0d errors", n_words, errors - e0);

      $display("3 tests, %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// ==== verilog.f ====
hdl/cache_geom_pkg.sv
hdl/cache_bus_pkg.sv
hdl/write_buffer.sv
hdl/plru_policy.sv
hdl/cache_ways.sv
hdl/cache_control.sv
hdl/cache_top.sv
sim/backend_model.sv
sim/cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then look for the fail message in the log
verilator --binary --timing --assert -Wno-fatal --top-module cache_tb \
   -f verilog.f -o cache_sim \
   && ./obj_dir/cache_sim > sim.log \
   && cat sim.log \
   && grep -q "Test passed" sim.log \
   && ! grep -q "Test failed" sim.log \
   && echo "simulation ok" \
   || { echo "simulation FAILED, see sim.log"; exit 1; }
